// ==== fp24_defines.svh ====
// fp24 sizes and pipeline latencies; nr stage count must stay within 1 to 4 stages
`ifndef FP24_DEFINES_SVH
`define FP24_DEFINES_SVH

// number format, 1 sign, 7 exponent, 16 fraction bits
`define FP24_W 24
`define FP24_EXP_W 7
`define FP24_FRAC_W 16

// exponent bias, zero exponent encodes zero
`define FP24_BIAS 63

// newton-raphson refinement count
`define INV_SQRT_NR_STAGES 2

// arithmetic unit latencies in cycles
`define FP24_MUL_LAT 1
`define FP24_ADD_LAT 2

// y*y, then x*y*y, then 3 - x*y*y, then the final multiply
`define INV_SQRT_STAGE_LAT (2 * `FP24_MUL_LAT + `FP24_ADD_LAT + `FP24_MUL_LAT)

`endif

// ==== fp24_pkg.sv ====
// fp24 number format only; no infinities, NaN or denormals, max exponent is a normal value
`include "fp24_defines.svh"

package fp24_pkg;

  // one fp24 number, msb first
  typedef struct packed {
    logic                    sign;
    logic [`FP24_EXP_W-1:0]  exp;
    logic [`FP24_FRAC_W-1:0] frac;
  } fp24_t;

  // 3.0, exponent bias+1 with fraction .5
  localparam fp24_t FP24_THREE = 24'h408000;

  // flush target
  localparam fp24_t FP24_ZERO = '0;

  // saturation target, all exponent and fraction bits set
  localparam fp24_t FP24_MAX = {1'b0, {`FP24_EXP_W{1'b1}}, {`FP24_FRAC_W{1'b1}}};

  // raw-bit constant for the first guess
  // works on the integer view of the encoding, not on the value
  localparam logic [`FP24_W-1:0] INV_SQRT_MAGIC = 24'h5e7a09;

endpackage

// ==== isqrt_pkg.sv ====
// token carried between newton-raphson stages; valid is a plain level with no back-pressure

package isqrt_pkg;

  // state handed from one stage to the next
  // x is the operand, y the current estimate
  typedef struct packed {
    fp24_pkg::fp24_t x;
    fp24_pkg::fp24_t y;
    logic            valid;
  } stage_tok_t;

endpackage

// ==== delay_line.sv ====
// fixed-depth register chain, every stage cleared to zero by reset; DEPTH must be 1 or more
`timescale 1ns/1ps
`include "fp24_defines.svh"

module delay_line #(
  parameter type T = logic,
  parameter int DEPTH = 1
) (
  input  logic clk,
  input  logic arst_n,
  input  T     d,
  output T     q
);

  // stage 0 takes d, last stage drives q
  T stage_q [DEPTH];

  // edges since reset, saturating at DEPTH
  int fill_cnt;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= d;
      // shift one place per cycle
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fill_cnt <= 0;
    end else if (fill_cnt < DEPTH) begin
      fill_cnt <= fill_cnt + 1;
    end
  end

  assign q = stage_q[DEPTH-1];

  // once the chain has refilled, q is d from DEPTH edges back
  a_depth_delay: assert property (@(posedge clk) disable iff (!arst_n)
    (fill_cnt >= DEPTH) |-> q === $past(d, DEPTH))
    else $error("delay_line output is not its input delayed by DEPTH cycles");

endmodule

// ==== fp24_mul.sv ====
// one-cycle fp24 multiply; truncates, underflow flushes to zero, overflow saturates to max
`timescale 1ns/1ps
`include "fp24_defines.svh"

module fp24_mul (
  input  logic            clk,
  input  fp24_pkg::fp24_t a,
  input  fp24_pkg::fp24_t b,
  output fp24_pkg::fp24_t prod
);

  // significand with hidden one
  localparam int sig_w = `FP24_FRAC_W + 1;
  localparam int prod_w = 2 * sig_w;
  // extra bits so the exponent sum can go negative or past max
  localparam int ew = `FP24_EXP_W + 3;
  localparam int max_exp = (1 << `FP24_EXP_W) - 1;

  logic [prod_w-1:0]   sig_prod;
  logic                norm;
  logic signed [ew-1:0] exp_sum;
  fp24_pkg::fp24_t     prod_c;

  always_comb begin
    sig_prod = {1'b1, a.frac} * {1'b1, b.frac};
    // product of two [1,2) values lands in [1,4)
    norm = sig_prod[prod_w-1];
    exp_sum = $signed({3'b000, a.exp}) + $signed({3'b000, b.exp})
              - $signed(ew'(`FP24_BIAS)) + $signed({{(ew-1){1'b0}}, norm});
    prod_c.sign = a.sign ^ b.sign;
    prod_c.exp = exp_sum[`FP24_EXP_W-1:0];
    // drop everything below the kept fraction
    if (norm) begin
      prod_c.frac = sig_prod[prod_w-2 -: `FP24_FRAC_W];
    end else begin
      prod_c.frac = sig_prod[prod_w-3 -: `FP24_FRAC_W];
    end
    // zero operand wins over everything
    if (a.exp == '0 || b.exp == '0) begin
      prod_c = fp24_pkg::FP24_ZERO;
    end else if (exp_sum <= 0) begin
      prod_c = fp24_pkg::FP24_ZERO;
    end else if (exp_sum > max_exp) begin
      prod_c = fp24_pkg::FP24_MAX;
    end
  end

  // output register, payload only
  always_ff @(posedge clk) begin
    prod <= prod_c;
  end

endmodule

// ==== fp24_add.sv ====
// two-cycle fp24 add/sub; shifted-out bits are dropped, result truncated, zero flushes clean
`timescale 1ns/1ps
`include "fp24_defines.svh"

module fp24_add (
  input  logic            clk,
  input  fp24_pkg::fp24_t a,
  input  fp24_pkg::fp24_t b,
  input  logic            is_sub,
  output fp24_pkg::fp24_t sum
);

  localparam int sig_w = `FP24_FRAC_W + 1;
  // one carry bit on top
  localparam int sum_w = sig_w + 1;
  localparam int lz_w = $clog2(sum_w + 1);
  localparam int ew = `FP24_EXP_W + 3;
  localparam int max_exp = (1 << `FP24_EXP_W) - 1;

  // align and add
  logic                   b_sign_eff;
  logic                   a_ge_b;
  fp24_pkg::fp24_t        hi_op;
  fp24_pkg::fp24_t        lo_op;
  logic                   hi_sign;
  logic                   lo_sign;
  logic [`FP24_EXP_W-1:0] exp_diff;
  logic [sig_w-1:0]       hi_sig;
  logic [sig_w-1:0]       lo_sig;
  logic [sig_w-1:0]       lo_aligned;
  logic [sum_w-1:0]       sig_res;

  // first pipe register
  logic                   s1_sign;
  logic [`FP24_EXP_W-1:0] s1_exp;
  logic [sum_w-1:0]       s1_sig;

  // normalize
  logic [lz_w-1:0]        lz;
  logic [sum_w-1:0]       norm_sig;
  logic signed [ew-1:0]   exp_norm;
  fp24_pkg::fp24_t        sum_c;

  always_comb begin
    // subtract is an add with b negated
    b_sign_eff = b.sign ^ is_sub;
    a_ge_b = {a.exp, a.frac} >= {b.exp, b.frac};
    if (a_ge_b) begin
      hi_op = a;
      lo_op = b;
      hi_sign = a.sign;
      lo_sign = b_sign_eff;
    end else begin
      hi_op = b;
      lo_op = a;
      hi_sign = b_sign_eff;
      lo_sign = a.sign;
    end
    exp_diff = hi_op.exp - lo_op.exp;
    // hidden bit only for nonzero exponent
    hi_sig = {hi_op.exp != '0, hi_op.frac};
    lo_sig = {lo_op.exp != '0, lo_op.frac};
    lo_aligned = lo_sig >> exp_diff;
    // larger magnitude first so the difference never goes negative
    if (hi_sign == lo_sign) begin
      sig_res = {1'b0, hi_sig} + {1'b0, lo_aligned};
    end else begin
      sig_res = {1'b0, hi_sig} - {1'b0, lo_aligned};
    end
  end

  always_ff @(posedge clk) begin
    s1_sign <= hi_sign;
    s1_exp <= hi_op.exp;
    s1_sig <= sig_res;
  end

  always_comb begin
    // leading zero count, highest set bit wins
    lz = lz_w'(sum_w);
    for (int i = 0; i < sum_w; i++) begin
      if (s1_sig[i]) begin
        lz = lz_w'(sum_w - 1 - i);
      end
    end
    norm_sig = s1_sig << lz;
    // lz of 0 means carry out, exponent goes up by one
    exp_norm = $signed({3'b000, s1_exp}) + $signed(ew'(1))
               - $signed({{(ew-lz_w){1'b0}}, lz});
    sum_c.sign = s1_sign;
    sum_c.exp = exp_norm[`FP24_EXP_W-1:0];
    sum_c.frac = norm_sig[sum_w-2 -: `FP24_FRAC_W];
    if (s1_sig == '0 || exp_norm <= 0) begin
      sum_c = fp24_pkg::FP24_ZERO;
    end else if (exp_norm > max_exp) begin
      sum_c = fp24_pkg::FP24_MAX;
    end
  end

  always_ff @(posedge clk) begin
    sum <= sum_c;
  end

  // a nonzero sum must come out of the shift with its hidden bit set
  a_norm_hidden: assert property (@(posedge clk)
    (!$isunknown(s1_sig) && s1_sig != '0) |-> norm_sig[sum_w-1])
    else $error("fp24_add normalize left the hidden bit clear");

endmodule

// ==== fp24_inv_sqrt_stage.sv ====
// one newton-raphson step y*(3-x*y*y)/2 over five cycles; assumes x positive and nonzero y
`timescale 1ns/1ps
`include "fp24_defines.svh"

module fp24_inv_sqrt_stage (
  input  logic                 clk,
  input  logic                 arst_n,
  input  isqrt_pkg::stage_tok_t tok_in,
  output isqrt_pkg::stage_tok_t tok_out
);

  fp24_pkg::fp24_t x_d1;
  fp24_pkg::fp24_t x_d5;
  fp24_pkg::fp24_t y_d4;
  fp24_pkg::fp24_t y_sq;
  fp24_pkg::fp24_t xy_sq;
  fp24_pkg::fp24_t diff;
  fp24_pkg::fp24_t half;
  fp24_pkg::fp24_t y_next;
  logic            valid_d5;

  // x meets y*y at the second multiplier
  delay_line #(.T(fp24_pkg::fp24_t), .DEPTH(`FP24_MUL_LAT)) u_x_d1 (
    .clk(clk), .arst_n(arst_n), .d(tok_in.x), .q(x_d1)
  );

  // y waits for the halved difference
  delay_line #(.T(fp24_pkg::fp24_t), .DEPTH(2 * `FP24_MUL_LAT + `FP24_ADD_LAT)) u_y_d4 (
    .clk(clk), .arst_n(arst_n), .d(tok_in.y), .q(y_d4)
  );

  // x and valid ride along for the next stage
  delay_line #(.T(fp24_pkg::fp24_t), .DEPTH(`INV_SQRT_STAGE_LAT)) u_x_d5 (
    .clk(clk), .arst_n(arst_n), .d(tok_in.x), .q(x_d5)
  );

  delay_line #(.DEPTH(`INV_SQRT_STAGE_LAT)) u_valid_d5 (
    .clk(clk), .arst_n(arst_n), .d(tok_in.valid), .q(valid_d5)
  );

  // cycle 1
  fp24_mul u_mul_y_sq (.clk(clk), .a(tok_in.y), .b(tok_in.y), .prod(y_sq));

  // cycle 2
  fp24_mul u_mul_xy_sq (.clk(clk), .a(y_sq), .b(x_d1), .prod(xy_sq));

  // cycles 3 and 4
  fp24_add u_add_sub (
    .clk(clk), .a(fp24_pkg::FP24_THREE), .b(xy_sq), .is_sub(1'b1), .sum(diff)
  );

  // divide by two on the exponent, no cycle
  always_comb begin
    half = diff;
    half.exp = diff.exp - 1'b1;
    // exp 1 would land on the zero encoding
    if (diff.exp <= 1) begin
      half = fp24_pkg::FP24_ZERO;
    end
  end

  // cycle 5
  fp24_mul u_mul_next (.clk(clk), .a(half), .b(y_d4), .prod(y_next));

  assign tok_out = '{x: x_d5, y: y_next, valid: valid_d5};

  // reset must reach every valid register in the chain
  a_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown(tok_out.valid))
    else $error("stage valid unknown after reset");

endmodule

// ==== fp24_inv_sqrt.sv ====
// fp24 inverse square root, latency is stage count times stage latency; positive inputs only
`timescale 1ns/1ps
`include "fp24_defines.svh"

module fp24_inv_sqrt (
  input  logic            clk,
  input  logic            arst_n,
  input  fp24_pkg::fp24_t x,
  input  logic            x_valid,
  output fp24_pkg::fp24_t inv_sqrt,
  output logic            inv_sqrt_valid
);

  localparam int nr_stages = `INV_SQRT_NR_STAGES;

  // token i feeds stage i
  isqrt_pkg::stage_tok_t tok [nr_stages+1];

  logic [`FP24_W-1:0] x_bits;
  logic [`FP24_W-1:0] guess_bits;

  // first guess on the raw encoding
  // halving the bits roughly halves the log, subtraction negates it
  assign x_bits = x;
  assign guess_bits = fp24_pkg::INV_SQRT_MAGIC - {1'b0, x_bits[`FP24_W-1:1]};

  assign tok[0] = '{x: x, y: fp24_pkg::fp24_t'(guess_bits), valid: x_valid};

  for (genvar i = 0; i < nr_stages; i++) begin : g_stage
    fp24_inv_sqrt_stage u_stage (
      .clk(clk),
      .arst_n(arst_n),
      .tok_in(tok[i]),
      .tok_out(tok[i+1])
    );
  end

  // last token carries the refined estimate
  assign inv_sqrt = tok[nr_stages].y;
  assign inv_sqrt_valid = tok[nr_stages].valid;

endmodule

// ==== tb_fp24_inv_sqrt.sv ====
// expects isqrt_patterns.txt built for 2 stages, run from the project root; one input per cycle max
`timescale 1ns/1ps
`include "fp24_defines.svh"

module tb_fp24_inv_sqrt;

  localparam int n_pat = 20;
  // stage count times stage latency
  localparam int lat = `INV_SQRT_NR_STAGES * `INV_SQRT_STAGE_LAT;
  localparam int n_tests = 4;
  // each test is at most one pattern pass with 3-cycle gaps, a drain and some slack
  localparam int cycle_limit = n_tests * (n_pat * 4 + lat + 20);

  logic            clk;
  logic            arst_n;
  fp24_pkg::fp24_t x;
  logic            x_valid;
  fp24_pkg::fp24_t inv_sqrt;
  logic            inv_sqrt_valid;

  // even words are inputs, odd words expected results
  logic [`FP24_W-1:0] pat_mem [2*n_pat];

  // results in flight, oldest first
  fp24_pkg::fp24_t val_q [$];
  int              due_q [$];

  int              cyc;
  int              clk_count = 0;
  int              pass_cnt;
  int              fail_cnt;
  int              test_fail_base;
  int              gap;
  logic [15:0]     lfsr;
  fp24_pkg::fp24_t val_drop;
  int              due_drop;

  fp24_inv_sqrt dut0 (
    .clk(clk),
    .arst_n(arst_n),
    .x(x),
    .x_valid(x_valid),
    .inv_sqrt(inv_sqrt),
    .inv_sqrt_valid(inv_sqrt_valid)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    clk_count <= clk_count + 1;
  end

  // watchdog
  initial begin
    wait (clk_count >= cycle_limit);
    $display("timeout, results never arrived within %0d cycles", cycle_limit);
    $display("Regression failed");
    $finish;
  end

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // two lfsr bits, gap of 0 to 3 idle cycles
  task automatic draw_gap(output int g);
    g = 0;
    for (int i = 0; i < 2; i++) begin
      g = (g << 1) | lfsr[15];
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic check_fp24(input string name, input fp24_pkg::fp24_t got,
                            input fp24_pkg::fp24_t exp);
    if (got !== exp) begin
      $display("Mismatch %s at cycle %0d: got %06h expected %06h", name, cyc, got, exp);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic check_valid(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s at cycle %0d: got %h expected %h", name, cyc, got, exp);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  // one clock: sample outputs, then drive the next input
  task automatic tick(input logic v, input fp24_pkg::fp24_t xin, input fp24_pkg::fp24_t y_exp);
    logic due;
    @(negedge clk);
    cyc++;
    // outputs are stable since the last rising edge
    due = (due_q.size() > 0) && (due_q[0] == cyc);
    check_valid("inv_sqrt_valid", inv_sqrt_valid, due);
    if (due) begin
      if (inv_sqrt_valid === 1'b1) begin
        check_fp24("inv_sqrt", inv_sqrt, val_q[0]);
      end
      val_drop = val_q.pop_front();
      due_drop = due_q.pop_front();
    end
    x = xin;
    x_valid = v;
    if (v) begin
      val_q.push_back(y_exp);
      due_q.push_back(cyc + lat);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) tick(1'b0, fp24_pkg::FP24_ZERO, fp24_pkg::FP24_ZERO);
  endtask

  task automatic send(input int idx);
    tick(1'b1, pat_mem[2*idx], pat_mem[2*idx+1]);
  endtask

  task automatic drain();
    while (due_q.size() > 0) begin
      idle(1);
    end
  endtask

  task automatic end_test(input string name);
    $display("test %s done, %0d errors", name, fail_cnt - test_fail_base);
    test_fail_base = fail_cnt;
  endtask

  initial begin
    x = fp24_pkg::FP24_ZERO;
    x_valid = 1'b0;
    arst_n = 1'b0;
    cyc = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    test_fail_base = 0;
    lfsr = 16'd60931;
    $readmemh("isqrt_patterns.txt", pat_mem);
    if ($isunknown(pat_mem[2*n_pat-1])) begin
      $display("pattern file isqrt_patterns.txt is missing or shorter than %0d lines", n_pat);
      fail_cnt++;
    end else begin
      idle(2);
      arst_n = 1'b1;
      // nothing may come out before the first input
      idle(lat + 2);
      send(0);
      drain();
      end_test("quiet after reset");
      for (int i = 0; i < n_pat; i++) begin
        send(i);
      end
      drain();
      end_test("back-to-back burst");
      for (int i = 0; i < n_pat; i++) begin
        send(i);
        draw_gap(gap);
        idle(gap);
      end
      drain();
      end_test("random gaps");
      for (int i = 0; i < 6; i++) begin
        send(i);
      end
      // last input is dropped with the rest of the pipe
      x_valid = 1'b0;
      arst_n = 1'b0;
      val_q.delete();
      due_q.delete();
      idle(2);
      arst_n = 1'b1;
      idle(lat + 2);
      for (int i = n_pat - 3; i < n_pat; i++) begin
        send(i);
      end
      drain();
      end_test("reset in flight");
    end
    $display("%0d checks passed, %0d checks failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+.
fp24_pkg.sv
isqrt_pkg.sv
delay_line.sv
fp24_mul.sv
fp24_add.sv
fp24_inv_sqrt_stage.sv
fp24_inv_sqrt.sv
tb_fp24_inv_sqrt.sv

// ==== isqrt_patterns.txt ====
// column 1 is the fp24 input x, column 2 the expected inv_sqrt, both hex
// expected values assume 2 stages, truncation, flush to zero and saturation
3f0000 3f0000 // 1.0
410000 3e0000 // 4.0
430000 3d0000 // 16.0
3d0000 400000 // 0.25
3b0000 410000 // 1/16
450000 3c0000 // 64.0
390000 420000 // 1/64
5d0000 300000 // 4^15
6f0000 270000 // 4^24
010000 5e0000 // smallest normal, 4^-31
400000 3e6a09 // 2.0
420000 3d6a09 // 8.0
440000 3c6a09 // 32.0
3e0000 3f6a09 // 0.5
3c0000 406a09 // 0.125
3f8000 3ea208 // 1.5
418000 3da208 // 6.0
3d8000 3fa208 // 0.375
000000 5fa949 // zero, x*y*y drops out
7f0000 201ca4 // 2^64, y*y flushes to zero
